/* flist.f */
+incdir+include
+incdir+verif
hw/pitch_pkg.sv
hw/pitch_stage_if.sv
hw/pitch_regs.sv
hw/slot_scheduler.sv
hw/note_lookup_stage.sv
hw/tune_interp_stage.sv
hw/ratio_stage.sv
hw/pitch_engine.sv
verif/tb_pitch_engine.sv

/* hw/note_lookup_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module note_lookup_stage (
    input  wire                   reg_clk,
    input  wire                   reset,
    input  wire                   issue,
    input  wire pitch_pkg::slot_t slot,
    input  wire [7:0]             key,
    input  wire [7:0]             base_coarse,
    input  wire [7:0]             base_fine,
    input  wire [7:0]             bend_range,
    input  wire [13:0]            bend,
    input  wire [7:0]             key_scale,
    input  wire [7:0]             ratio_coarse,
    input  wire [7:0]             ratio_fine,
    pitch_stage_if.source         out
);
    import pitch_pkg::*;

    logic signed [10:0] shifted;
    logic signed [10:0] center_s;
    logic [7:0]         center_key;
    logic [7:0]         fine_key;
    logic [7:0]         bend_key;

    function automatic logic [7:0] clamp_key(input logic signed [10:0] k);
        if (k < 0) begin
            return 8'd0;
        end
        if (k > KEY_MAX) begin
            return 8'(KEY_MAX);
        end
        return k[7:0];
    endfunction

    assign shifted    = $signed({3'b0, key}) + $signed({3'b0, base_coarse}) - 11'sd64;
    assign center_key = clamp_key(shifted);
    assign center_s   = $signed({3'b0, center_key});

    assign fine_key = (base_fine <= 8'd63) ? clamp_key(center_s - 11'sd1)
                                           : clamp_key(center_s + 11'sd1);

    assign bend_key = (bend < 14'h2000) ? clamp_key(center_s - $signed({3'b0, bend_range}))
                                        : clamp_key(center_s + $signed({3'b0, bend_range}));

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= issue;
        end
    end

    // tuning sampled here travels with the slot
    always_ff @(posedge reg_clk) begin
        out.data.slot         <= slot;
        out.data.inc_center   <= note_increment(center_key);
        out.data.inc_fine     <= note_increment(fine_key);
        out.data.inc_bend     <= note_increment(bend_key);
        out.data.base_fine    <= base_fine;
        out.data.bend         <= bend;
        out.data.key_scale    <= key_scale;
        out.data.ratio_coarse <= ratio_coarse;
        out.data.ratio_fine   <= ratio_fine;
    end

endmodule

`default_nettype wire

/* hw/pitch_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pitch_settings.svh"

module pitch_engine (
    input  wire                           reg_clk,
    input  wire                           reset,
    input  wire                           osc_sel,
    input  wire                           com_sel,
    input  wire                           write,
    input  wire                           read,
    input  wire [6:0]                     adr,
    input  wire [7:0]                     wr_data,
    output logic [7:0]                    rd_data,
    input  wire                           key_write,
    input  wire [pitch_pkg::VOICE_W-1:0]  key_voice,
    input  wire [7:0]                     key_val,
    input  wire [13:0]                    bend,
    input  wire                           out_credit,
    output logic                          out_valid,
    output logic [pitch_pkg::VOICE_W-1:0] out_voice,
    output logic [pitch_pkg::OSC_W-1:0]   out_osc,
    output logic [`PITCH_WIDTH-1:0]       out_pitch
);
    import pitch_pkg::*;

    slot_t      slot;
    logic       issue;
    logic [7:0] key;
    logic [7:0] ratio_coarse;
    logic [7:0] ratio_fine;
    logic [7:0] key_scale;
    logic [7:0] base_coarse;
    logic [7:0] base_fine;
    logic [7:0] bend_range;

    pitch_stage_if #(.payload_t(lookup_t)) lookup_bus ();
    pitch_stage_if #(.payload_t(tuned_t))  tuned_bus ();

    pitch_regs u_regs (
        .reg_clk(reg_clk), .reset(reset), .osc_sel(osc_sel), .com_sel(com_sel),
        .write(write), .read(read), .adr(adr), .wr_data(wr_data), .rd_data(rd_data),
        .key_write(key_write), .key_voice(key_voice), .key_val(key_val),
        .slot(slot), .key(key), .ratio_coarse(ratio_coarse), .ratio_fine(ratio_fine),
        .key_scale(key_scale), .base_coarse(base_coarse), .base_fine(base_fine),
        .bend_range(bend_range)
    );

    slot_scheduler u_sched (
        .reg_clk(reg_clk), .reset(reset), .out_credit(out_credit),
        .slot(slot), .issue(issue)
    );

    note_lookup_stage u_lookup (
        .reg_clk(reg_clk), .reset(reset), .issue(issue), .slot(slot), .key(key),
        .base_coarse(base_coarse), .base_fine(base_fine), .bend_range(bend_range),
        .bend(bend), .key_scale(key_scale), .ratio_coarse(ratio_coarse),
        .ratio_fine(ratio_fine), .out(lookup_bus)
    );

    tune_interp_stage u_interp (
        .reg_clk(reg_clk), .reset(reset), .in(lookup_bus), .out(tuned_bus)
    );

    ratio_stage u_ratio (
        .reg_clk(reg_clk), .reset(reset), .in(tuned_bus), .out_valid(out_valid),
        .out_voice(out_voice), .out_osc(out_osc), .out_pitch(out_pitch)
    );

endmodule

`default_nettype wire

/* hw/pitch_pkg.sv */
`default_nettype none

`include "pitch_settings.svh"

package pitch_pkg;

    localparam int VOICE_W = $clog2(`PITCH_VOICES);
    localparam int OSC_W   = $clog2(`PITCH_OSCS);
    localparam int KEY_MAX = 143;  // top of the note table

    typedef logic [`PITCH_WIDTH-1:0] pitch_t;

    typedef struct packed {
        logic [VOICE_W-1:0] voice;
        logic [OSC_W-1:0]   osc;
    } slot_t;

    typedef struct packed {
        slot_t       slot;
        pitch_t      inc_center;
        pitch_t      inc_fine;      // neighbor key for base fine
        pitch_t      inc_bend;      // key at full bend
        logic [7:0]  base_fine;
        logic [13:0] bend;
        logic [7:0]  key_scale;
        logic [7:0]  ratio_coarse;
        logic [7:0]  ratio_fine;
    } lookup_t;

    typedef struct packed {
        slot_t      slot;
        pitch_t     pitch;
        logic [7:0] ratio_coarse;
        logic [7:0] ratio_fine;
    } tuned_t;

    // offsets inside an oscillator block, block n starts at 16*n
    localparam logic [3:0] REG_RATIO_COARSE = 4'd0;
    localparam logic [3:0] REG_RATIO_FINE   = 4'd1;
    localparam logic [3:0] REG_KEY_SCALE    = 4'd5;
    localparam logic [3:0] REG_BASE_COARSE  = 4'd8;
    localparam logic [3:0] REG_BASE_FINE    = 4'd9;
    localparam logic [6:0] REG_BEND_RANGE   = 7'd0;  // common block

    // lowest octave, 24-bit phase at 48 kHz
    localparam logic [12:0] SEMITONE_BASE [12] = '{
        13'd2858, 13'd3028, 13'd3208, 13'd3399, 13'd3601, 13'd3815,
        13'd4042, 13'd4282, 13'd4537, 13'd4807, 13'd5092, 13'd5395
    };

    // Tuning rules, 64 is centre for every tuning register.
    // base coarse: key moves by value - 64, keys clamp to 0..KEY_MAX
    // base fine: v <= 63 leans to key-1 with weight 64-v, else key+1 with v[5:0], /64
    // bend b: b < 8192 leans to key-range with 8192-b, else key+range with b[12:0], /8192
    // key scale adds 16 * value after fine and bend
    // ratio coarse c: c <= 64 divides by 65-c, above 64 multiplies by c-63
    // ratio fine leans to step c-1 or c+1 with the base fine weights, /64

    function automatic pitch_t note_increment(input logic [7:0] key);
        logic [7:0] k;
        k = (key > 8'(KEY_MAX)) ? 8'(KEY_MAX) : key;
        return pitch_t'(SEMITONE_BASE[k % 12]) << (k / 12);
    endfunction

    function automatic logic [6:0] fine_weight(input logic [7:0] v);
        return (v <= 8'd63) ? 7'(8'd64 - v) : {1'b0, v[5:0]};
    endfunction

    // move from a toward b by w / 2**sh
    function automatic pitch_t lerp(input pitch_t a, input pitch_t b,
                                    input logic [13:0] w, input int unsigned sh);
        logic [`PITCH_WIDTH+13:0] span;
        span = (b >= a) ? (b - a) * w : (a - b) * w;
        return (b >= a) ? a + pitch_t'(span >> sh) : a - pitch_t'(span >> sh);
    endfunction

    // s runs from -1 to 256 so the neighbor steps stay defined
    function automatic pitch_t coarse_step(input pitch_t p, input logic signed [9:0] s);
        logic [`PITCH_WIDTH+8:0] prod;
        prod = p * 9'(s - 10'sd63);
        if (s <= 10'sd64) begin
            return p / pitch_t'(10'sd65 - s);
        end
        return prod[`PITCH_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* hw/pitch_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pitch_settings.svh"

module pitch_regs (
    input  wire                          reg_clk,
    input  wire                          reset,
    input  wire                          osc_sel,
    input  wire                          com_sel,
    input  wire                          write,
    input  wire                          read,
    input  wire [6:0]                    adr,
    input  wire [7:0]                    wr_data,
    output logic [7:0]                   rd_data,
    input  wire                          key_write,
    input  wire [pitch_pkg::VOICE_W-1:0] key_voice,
    input  wire [7:0]                    key_val,
    input  wire pitch_pkg::slot_t        slot,
    output logic [7:0]                   key,
    output logic [7:0]                   ratio_coarse,
    output logic [7:0]                   ratio_fine,
    output logic [7:0]                   key_scale,
    output logic [7:0]                   base_coarse,
    output logic [7:0]                   base_fine,
    output logic [7:0]                   bend_range
);
    import pitch_pkg::*;

    logic [7:0] ratio_coarse_r [`PITCH_OSCS];
    logic [7:0] ratio_fine_r [`PITCH_OSCS];
    logic [7:0] key_scale_r [`PITCH_OSCS];
    logic [7:0] base_coarse_r [`PITCH_OSCS];
    logic [7:0] base_fine_r [`PITCH_OSCS];
    logic [7:0] bend_range_r;
    logic [7:0] keys [`PITCH_VOICES];
    logic [OSC_W-1:0] osc;
    logic             osc_hit;

    assign osc     = adr[4 +: OSC_W];
    assign osc_hit = osc_sel && (int'(adr[6:4]) < `PITCH_OSCS);  // block exists

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            for (int i = 0; i < `PITCH_OSCS; i++) begin
                ratio_coarse_r[i] <= 8'd64;
                ratio_fine_r[i]   <= 8'd64;
                key_scale_r[i]    <= 8'd0;
                base_coarse_r[i]  <= 8'd64;
                base_fine_r[i]    <= 8'd64;
            end
            for (int v = 0; v < `PITCH_VOICES; v++) begin
                keys[v] <= 8'd60;
            end
            bend_range_r <= 8'd3;
        end else begin
            if (write && osc_hit) begin
                case (adr[3:0])
                    REG_RATIO_COARSE: ratio_coarse_r[osc] <= wr_data;
                    REG_RATIO_FINE:   ratio_fine_r[osc]   <= wr_data;
                    REG_KEY_SCALE:    key_scale_r[osc]    <= wr_data;
                    REG_BASE_COARSE:  base_coarse_r[osc]  <= wr_data;
                    REG_BASE_FINE:    base_fine_r[osc]    <= wr_data;
                    default: ;  // holes in the block
                endcase
            end else if (write && com_sel && adr == REG_BEND_RANGE) begin
                bend_range_r <= wr_data;
            end
            if (key_write) begin
                keys[key_voice] <= key_val;
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            rd_data <= 8'd0;
        end else if (read && osc_hit) begin
            case (adr[3:0])
                REG_RATIO_COARSE: rd_data <= ratio_coarse_r[osc];
                REG_RATIO_FINE:   rd_data <= ratio_fine_r[osc];
                REG_KEY_SCALE:    rd_data <= key_scale_r[osc];
                REG_BASE_COARSE:  rd_data <= base_coarse_r[osc];
                REG_BASE_FINE:    rd_data <= base_fine_r[osc];
                default:          rd_data <= 8'd0;
            endcase
        end else if (read && com_sel) begin
            rd_data <= (adr == REG_BEND_RANGE) ? bend_range_r : 8'd0;
        end else if (read) begin
            rd_data <= 8'd0;  // no block at this address
        end
    end

    // tuning set of the slot being issued
    assign key          = keys[slot.voice];
    assign ratio_coarse = ratio_coarse_r[slot.osc];
    assign ratio_fine   = ratio_fine_r[slot.osc];
    assign key_scale    = key_scale_r[slot.osc];
    assign base_coarse  = base_coarse_r[slot.osc];
    assign base_fine    = base_fine_r[slot.osc];
    assign bend_range   = bend_range_r;

    single_select: assert property (@(posedge reg_clk) disable iff (reset)
        write |-> !(osc_sel && com_sel));

endmodule

`default_nettype wire

/* hw/pitch_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pitch_stage_if #(
    parameter type payload_t = pitch_pkg::lookup_t
);
    import pitch_pkg::*;

    logic     valid;  // data taken every cycle this is high
    payload_t data;
    slot_t    slot;

    assign slot = data.slot;

    modport source (output valid, output data);
    modport sink (input valid, input slot, input data);

endinterface

`default_nettype wire

/* hw/ratio_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pitch_settings.svh"

module ratio_stage (
    input  wire                           reg_clk,
    input  wire                           reset,
    pitch_stage_if.sink                   in,
    output logic                          out_valid,
    output logic [pitch_pkg::VOICE_W-1:0] out_voice,
    output logic [pitch_pkg::OSC_W-1:0]   out_osc,
    output logic [`PITCH_WIDTH-1:0]       out_pitch
);
    import pitch_pkg::*;

    logic signed [9:0] step_c;
    logic signed [9:0] step_n;
    logic              valid_q;
    slot_t             slot_q;
    pitch_t            p_coarse;
    pitch_t            p_next;
    logic [7:0]        fine_q;

    assign step_c = $signed({2'b00, in.data.ratio_coarse});
    assign step_n = (in.data.ratio_fine <= 8'd63) ? step_c - 10'sd1 : step_c + 10'sd1;

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= in.valid;
            out_valid <= valid_q;
        end
    end

    // first step, coarse ratio and its neighbor
    always_ff @(posedge reg_clk) begin
        slot_q   <= in.slot;
        p_coarse <= coarse_step(in.data.pitch, step_c);
        p_next   <= coarse_step(in.data.pitch, step_n);
        fine_q   <= in.data.ratio_fine;
    end

    // second step, fine ratio between them
    always_ff @(posedge reg_clk) begin
        out_voice <= slot_q.voice;
        out_osc   <= slot_q.osc;
        out_pitch <= lerp(p_coarse, p_next, 14'(fine_weight(fine_q)), 6);
    end

endmodule

`default_nettype wire

/* hw/slot_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pitch_settings.svh"

module slot_scheduler (
    input  wire              reg_clk,
    input  wire              reset,
    input  wire              out_credit,
    output pitch_pkg::slot_t slot,
    output logic             issue
);
    import pitch_pkg::*;

    localparam int CREDIT_W = $clog2(`PITCH_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    logic [VOICE_W-1:0]  voice;
    logic [OSC_W-1:0]    osc;

    assign issue = (credits != '0);
    assign slot  = '{voice: voice, osc: osc};

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            credits <= CREDIT_W'(`PITCH_CREDITS);
        end else begin
            case ({issue, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;  // spent and returned together
            endcase
        end
    end

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            voice <= '0;
            osc   <= '0;
        end else if (issue) begin
            if (osc == OSC_W'(`PITCH_OSCS - 1)) begin
                osc   <= '0;
                voice <= (voice == VOICE_W'(`PITCH_VOICES - 1)) ? '0 : voice + 1'b1;
            end else begin
                osc <= osc + 1'b1;  // oscillator runs fastest
            end
        end
    end

    credit_bound: assert property (@(posedge reg_clk) disable iff (reset)
        credits <= CREDIT_W'(`PITCH_CREDITS));

endmodule

`default_nettype wire

/* hw/tune_interp_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tune_interp_stage (
    input  wire           reg_clk,
    input  wire           reset,
    pitch_stage_if.sink   in,
    pitch_stage_if.source out
);
    import pitch_pkg::*;

    logic [13:0] bend_w;
    pitch_t      pitch_fine;
    pitch_t      pitch_bend;
    pitch_t      scale_add;

    // weight from centre, direction already chosen by the bend key
    assign bend_w = (in.data.bend < 14'h2000) ? 14'h2000 - in.data.bend
                                              : {1'b0, in.data.bend[12:0]};

    assign pitch_fine = lerp(in.data.inc_center, in.data.inc_fine,
                             14'(fine_weight(in.data.base_fine)), 6);
    assign pitch_bend = lerp(pitch_fine, in.data.inc_bend, bend_w, 13);
    assign scale_add  = pitch_t'({in.data.key_scale, 4'b0000});  // 16 per step

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge reg_clk) begin
        out.data.slot         <= in.slot;
        out.data.pitch        <= pitch_bend + scale_add;
        out.data.ratio_coarse <= in.data.ratio_coarse;
        out.data.ratio_fine   <= in.data.ratio_fine;
    end

endmodule

`default_nettype wire

/* include/pitch_settings.svh */
`ifndef PITCH_SETTINGS_SVH
`define PITCH_SETTINGS_SVH

// voice block geometry
`define PITCH_VOICES  8
`define PITCH_OSCS    4

`define PITCH_CREDITS 4   // slots the consumer can hold
`define PITCH_WIDTH   24  // phase increment bits

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the pitch engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_pitch_engine -o sim_pitch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_pitch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0

/* verif/tb_pitch_checks.svh */
`ifndef TB_PITCH_CHECKS_SVH
`define TB_PITCH_CHECKS_SVH

localparam longint PMASK = 64'hFF_FFFF;

function automatic int clamp_note(input int k);
    return (k < 0) ? 0 : ((k > 143) ? 143 : k);
endfunction

// semitone entry raised by whole octaves, k already clamped
function automatic longint note_inc(input int k);
    return longint'(SEMITONE_BASE[k % 12]) << (k / 12);
endfunction

// step from a toward b by w / 2**sh, truncated toward a
function automatic longint move_toward(input longint a, input longint b,
                                      input longint w, input int sh);
    if (b >= a) begin
        return a + (((b - a) * w) >>> sh);
    end
    return a - (((a - b) * w) >>> sh);
endfunction

function automatic longint weight64(input int v);
    return (v <= 63) ? longint'(64 - v) : longint'(v % 64);
endfunction

function automatic longint apply_ratio(input longint p, input int s);
    if (s <= 64) begin
        return p / longint'(65 - s);
    end
    return (p * longint'(s - 63)) & PMASK;
endfunction

function automatic logic [23:0] expected_pitch(input int v, input int o);
    int center;
    int fine_k;
    int bend_k;
    longint bend_w;
    longint p;
    longint pc;
    longint pn;
    center = clamp_note(keys[v] + sh_bc[o] - 64);
    fine_k = clamp_note((sh_bf[o] <= 63) ? center - 1 : center + 1);
    bend_k = clamp_note((bend_val < 8192) ? center - sh_br : center + sh_br);
    bend_w = (bend_val < 8192) ? longint'(8192 - bend_val) : longint'(bend_val % 8192);
    p = move_toward(note_inc(center), note_inc(fine_k), weight64(sh_bf[o]), 6);
    p = move_toward(p, note_inc(bend_k), bend_w, 13);
    p = (p + 16 * sh_ks[o]) & PMASK;
    pc = apply_ratio(p, sh_rc[o]);
    pn = apply_ratio(p, (sh_rf[o] <= 63) ? sh_rc[o] - 1 : sh_rc[o] + 1);
    return 24'(move_toward(pc, pn, weight64(sh_rf[o]), 6));
endfunction

slot_order: assert property (@(posedge reg_clk) disable iff (reset)
    out_valid |-> (int'(out_voice) == exp_voice && int'(out_osc) == exp_osc))
    else begin
        errors++;
        $display("CHECK FAILED at %0t: slot %0d.%0d, expected %0d.%0d",
                 $time, out_voice, out_osc, exp_voice, exp_osc);
    end

pitch_value: assert property (@(posedge reg_clk) disable iff (reset)
    out_valid |-> out_pitch == expected_pitch(int'(out_voice), int'(out_osc)))
    else begin
        errors++;
        $display("CHECK FAILED at %0t: pitch %0d for slot %0d.%0d", $time, out_pitch,
                 out_voice, out_osc);
    end

credit_limit: assert property (@(posedge reg_clk) disable iff (reset)
    owed <= `PITCH_CREDITS)
    else begin
        errors++;
        $display("CHECK FAILED at %0t: %0d items held by consumer", $time, owed);
    end

readback: assert property (@(posedge reg_clk) disable iff (reset)
    rd_check |=> rd_data == $past(rd_expect))
    else begin
        errors++;
        $display("CHECK FAILED at %0t: rd_data %0d, expected %0d", $time, rd_data,
                 $past(rd_expect));
    end

`endif

/* verif/tb_pitch_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pitch_settings.svh"

module tb_pitch_engine;
    import pitch_pkg::*;

    localparam int PHASES = 5;

    logic reg_clk = 1'b0;
    logic out_credit = 1'b0;
    logic reset, osc_sel, com_sel, write, read, key_write, out_valid;
    logic [6:0] adr;
    logic [7:0] wr_data, rd_data, key_val, rd_expect;
    logic [VOICE_W-1:0] key_voice, out_voice;
    logic [OSC_W-1:0] out_osc;
    logic [13:0] bend;
    logic [`PITCH_WIDTH-1:0] out_pitch;
    logic rd_check, credit_en;
    logic [31:0] rng = 32'd89;
    int sh_rc[4], sh_rf[4], sh_ks[4], sh_bc[4], sh_bf[4], keys[8];
    int sh_br, bend_val, owed, errors, out_count, slot_idx, exp_voice, exp_osc;

    `include "tb_pitch_checks.svh"

    pitch_engine u_dut (.*);

    always #50 reg_clk = ~reg_clk;

    assign bend = 14'(bend_val);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift(rng);
        return int'(rng % n);
    endfunction

    // consumer: counts arrivals, returns one credit per cycle when allowed
    always @(negedge reg_clk) begin
        if (reset) begin
            owed = 0;
            out_credit <= 1'b0;
        end else begin
            if (out_valid) begin
                exp_voice = slot_idx / `PITCH_OSCS;  // checked on the next rising edge
                exp_osc   = slot_idx % `PITCH_OSCS;
                owed++;
                out_count++;
                slot_idx = (slot_idx + 1) % (`PITCH_VOICES * `PITCH_OSCS);
            end
            if (credit_en && owed > 0) begin
                out_credit <= 1'b1;
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    function automatic int shadow_read(input logic osc, input logic [6:0] a);
        if (osc && a[6:4] < 4) begin
            case (a[3:0])
                4'd0: return sh_rc[a[5:4]];
                4'd1: return sh_rf[a[5:4]];
                4'd5: return sh_ks[a[5:4]];
                4'd8: return sh_bc[a[5:4]];
                4'd9: return sh_bf[a[5:4]];
                default: return 0;
            endcase
        end
        return (!osc && a == 7'd0) ? sh_br : 0;
    endfunction

    // block offsets of the five tuning registers
    function automatic logic [3:0] tuning_offset(input int k);
        case (k)
            0: return REG_RATIO_COARSE;
            1: return REG_RATIO_FINE;
            2: return REG_KEY_SCALE;
            3: return REG_BASE_COARSE;
            default: return REG_BASE_FINE;
        endcase
    endfunction

    // each bus task starts and ends on a falling edge
    task automatic write_reg(input logic osc, input logic [6:0] a, input int d);
        {osc_sel, com_sel, write, adr, wr_data} = {osc, !osc, 1'b1, a, 8'(d)};
        if (osc && a[6:4] < 4) begin
            case (a[3:0])
                4'd0: sh_rc[a[5:4]] = d;
                4'd1: sh_rf[a[5:4]] = d;
                4'd5: sh_ks[a[5:4]] = d;
                4'd8: sh_bc[a[5:4]] = d;
                4'd9: sh_bf[a[5:4]] = d;
                default: ;
            endcase
        end else if (!osc && a == 7'd0) begin
            sh_br = d;
        end
        @(negedge reg_clk);
        {osc_sel, com_sel, write} = 3'b000;
    endtask

    task automatic read_reg(input logic osc, input logic [6:0] a);
        {osc_sel, com_sel, read, adr} = {osc, !osc, 1'b1, a};
        rd_expect = 8'(shadow_read(osc, a));
        rd_check = 1'b1;
        @(negedge reg_clk);
        {osc_sel, com_sel, read, rd_check} = 4'b0000;
    endtask

    task automatic set_key(input int v, input int k);
        {key_write, key_voice, key_val} = {1'b1, VOICE_W'(v), 8'(k)};
        keys[v] = k;
        @(negedge reg_clk);
        key_write = 1'b0;
    endtask

    task automatic drain;
        credit_en = 1'b0;
        while (owed != `PITCH_CREDITS) @(negedge reg_clk);
    endtask

    task automatic run_outputs(input int n);
        int target;
        target = out_count + n;
        credit_en = 1'b1;
        while (out_count < target) @(negedge reg_clk);
    endtask

    initial begin
        {osc_sel, com_sel, write, read, key_write, adr, wr_data} = '0;
        {key_voice, key_val, rd_check, credit_en, out_count, slot_idx, errors} = '0;
        for (int i = 0; i < 4; i++) begin
            {sh_rc[i], sh_rf[i], sh_ks[i], sh_bc[i], sh_bf[i]} = {32'd64, 32'd64, 32'd0,
                                                                  32'd64, 32'd64};
        end
        foreach (keys[v]) keys[v] = 60;
        sh_br = 3;
        bend_val = 8192;
        reset = 1'b1;
        repeat (8) @(negedge reg_clk);
        reset = 1'b0;
        run_outputs(64);  // default tuning, order
        drain();
        for (int i = 0; i < 24; i++) begin
            write_reg(1'b1, 7'(rand_below(128)), rand_below(256));  // holes included
            write_reg(1'b0, 7'(rand_below(4)), rand_below(256));
            read_reg(i[0], 7'(rand_below(i[0] ? 128 : 4)));
        end
        for (int i = 0; i < 5; i++) begin
            foreach (sh_rc[o]) read_reg(1'b1, 7'({o[1:0], tuning_offset(i)}));
        end
        for (int r = 0; r < 6; r++) begin
            drain();
            for (int o = 0; o < 4; o++) begin
                for (int k = 0; k < 5; k++) begin
                    write_reg(1'b1, 7'({o[1:0], tuning_offset(k)}), rand_below(256));
                end
            end
            write_reg(1'b0, 7'd0, rand_below(13));
            foreach (keys[v]) set_key(v, rand_below(256));
            bend_val = rand_below(16384);
            run_outputs(40);
        end
        drain();
        repeat (20) @(negedge reg_clk);  // credits withheld
        run_outputs(32);
        drain();
        set_key(3, rand_below(144));
        run_outputs(64);
        $display("outputs %0d, errors %0d", out_count, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (PHASES * 2000) @(posedge reg_clk);
        $display("watchdog expired after %0d outputs, run did not finish", out_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
